// File: hdl/tdc_fifo.sv
// synchronous first-word-fall-through FIFO
// circular buffer with occupancy count, payload given by a type parameter
`timescale 1ns/10ps
`default_nettype none

module tdc_fifo #(
    parameter int  depth     = 8,
    parameter type payload_t = logic [31:0]
) (
    input  wire logic     CLK40,
    input  wire logic     RST_SYNC,
    input  wire logic     clear,
    input  wire logic     write,
    input  wire payload_t data_in,
    input  wire logic     read,
    output payload_t      data_out,
    output logic          full,
    output logic          empty
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);

    payload_t      mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [cw-1:0] count;
    logic          do_write;
    logic          do_read;

    // wrap at depth, which need not be a power of two
    function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] ptr);
        if (ptr == aw'(depth - 1)) begin
            return '0;
        end
        return ptr + aw'(1);
    endfunction

    assign full     = (count == cw'(depth));
    assign empty    = (count == '0);
    assign do_write = write && !full;  // dropped when full
    assign do_read  = read && !empty;  // ignored when empty
    assign data_out = mem[rd_ptr];     // head word

    always_ff @(posedge CLK40) begin
        if (do_write) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge CLK40) begin
        if (RST_SYNC || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + cw'(1);
                2'b01:   count <= count - cw'(1);
                default: count <= count;  // idle or both
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/tdc_measure.sv
// measurement core of the TDC channel
// FSM with enable and arm rules, tot accumulation with overflow,
// timestamp capture, event and lost-word counters, event word assembly
`timescale 1ns/10ps
`default_nettype none

module tdc_measure #(
    parameter logic [3:0] data_identifier = 4'd4
) (
    input  wire logic              CLK40,
    input  wire logic              RST_SYNC,
    input  wire logic              soft_clear,
    input  wire tdc_pkg::tdc_cfg_t cfg,
    input  wire logic              ext_en,
    input  wire logic              arm_tdc,
    input  wire logic [15:0]       timestamp,
    input  wire logic [4:0]        ones_cnt,
    input  wire logic              one_detected,
    input  wire logic              zero_detected,
    input  wire logic              small_tot,
    input  wire logic              fifo_full,
    output tdc_pkg::tdc_word_t     event_word,
    output logic                   event_valid,
    output logic [15:0]            event_cnt,
    output logic [7:0]             lost_cnt
);
    import tdc_pkg::*;

    tdc_state_t  state;
    tdc_state_t  next_state;
    logic        clear;
    logic        chan_en;
    logic        start;
    logic        short_evt;
    logic        finish;
    logic [12:0] acc;        // running sum, bit 12 spare
    logic [12:0] acc_sum;
    logic        acc_ovf;    // sticky overflow
    logic [15:0] start_ts;
    logic [15:0] stamp_val;
    logic [11:0] tot_val;

    assign clear   = RST_SYNC || soft_clear;
    assign chan_en = cfg.en || (cfg.en_ext && ext_en);

    always_ff @(posedge CLK40) begin
        if (clear) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (chan_en && !cfg.en_arm && one_detected && !small_tot) begin
                    next_state = st_count;
                end else if (chan_en && cfg.en_arm && arm_tdc) begin
                    next_state = st_armed;
                end
            end
            st_armed: begin
                if (!chan_en || small_tot) begin
                    next_state = st_idle;  // short pulse still recorded
                end else if (one_detected) begin
                    next_state = st_count;
                end
            end
            st_count: begin
                if (zero_detected || !chan_en) begin
                    next_state = st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    // pulse begins and ends inside one word
    assign short_evt = small_tot && chan_en &&
                       ((state == st_idle && !cfg.en_arm) || state == st_armed);

    assign start  = (state != st_count) && (next_state == st_count);
    assign finish = short_evt || (state == st_count && next_state == st_idle);

    assign acc_sum = acc + 13'(ones_cnt);

    always_ff @(posedge CLK40) begin
        if (start) begin
            acc      <= 13'(ones_cnt);
            start_ts <= timestamp;  // time of the start word
        end else if (state == st_count && !acc_ovf) begin
            acc <= acc_sum;
        end
    end

    always_ff @(posedge CLK40) begin
        if (clear) begin
            acc_ovf <= 1'b0;
        end else if (start) begin
            acc_ovf <= 1'b0;
        end else if (state == st_count && acc_sum > 13'(tot_max)) begin
            acc_ovf <= 1'b1;
        end
    end

    always_comb begin
        if (short_evt) begin
            tot_val = 12'(ones_cnt);
        end else if (acc_ovf || acc_sum > 13'(tot_max)) begin
            tot_val = '0;  // overflow bin
        end else begin
            tot_val = acc_sum[11:0];
        end
    end

    always_comb begin
        if (!cfg.en_write_ts) begin
            stamp_val = event_cnt;
        end else if (short_evt) begin
            stamp_val = timestamp;  // start word is this word
        end else begin
            stamp_val = start_ts;
        end
    end

    always_ff @(posedge CLK40) begin
        if (clear) begin
            event_cnt <= '0;
            lost_cnt  <= '0;
        end else if (finish) begin
            event_cnt <= event_cnt + 16'd1;  // counts dropped words too
            if (fifo_full && lost_cnt != 8'hff) begin
                lost_cnt <= lost_cnt + 8'd1;
            end
        end
    end

    assign event_word  = '{ident: data_identifier, stamp: stamp_val, tot: tot_val};
    assign event_valid = finish;

endmodule

`default_nettype wire

// File: hdl/tdc_pkg.sv
// shared definitions for the TDC channel
// event word and config structs, FSM states, register map
`default_nettype none

package tdc_pkg;

    typedef struct packed {
        logic [3:0]  ident;  // channel identifier
        logic [15:0] stamp;  // event count or start timestamp
        logic [11:0] tot;    // time over threshold, 0 on overflow
    } tdc_word_t;

    // config byte bits 3..0, en is bit 0
    typedef struct packed {
        logic en_ext;       // allow hardware enable
        logic en_write_ts;  // stamp carries timestamp
        logic en_arm;       // measure only after arm strobe
        logic en;           // software enable
    } tdc_cfg_t;

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_armed = 2'd1,
        st_count = 2'd2
    } tdc_state_t;

    // byte-wide register map
    localparam logic [15:0] reg_soft_rst = 16'd0;
    localparam logic [15:0] reg_config   = 16'd1;
    localparam logic [15:0] reg_lost_cnt = 16'd2;
    localparam logic [15:0] reg_event_lo = 16'd3;
    localparam logic [15:0] reg_event_hi = 16'd4;

    localparam logic [11:0] tot_max = 12'd4095;  // largest valid tot

endpackage

`default_nettype wire

// File: hdl/tdc_regs.sv
// byte-wide register bank of the TDC channel
// soft reset, configuration byte, counter readback with event count snapshot
`timescale 1ns/10ps
`default_nettype none

module tdc_regs (
    input  wire logic        CLK40,
    input  wire logic        RST_SYNC,
    input  wire logic [15:0] bus_add,
    input  wire logic [7:0]  bus_data_in,
    input  wire logic        bus_wr,
    input  wire logic        bus_rd,
    output logic      [7:0]  bus_data_out,
    output tdc_pkg::tdc_cfg_t cfg,
    output logic             soft_clear,
    input  wire logic [15:0] event_cnt,
    input  wire logic [7:0]  lost_cnt
);
    import tdc_pkg::*;

    logic        soft_wr;
    logic [7:0]  cfg_byte;
    logic [15:0] event_snap;  // latched on low byte read

    assign soft_wr = bus_wr && (bus_add == reg_soft_rst);

    always_ff @(posedge CLK40) begin
        if (RST_SYNC) begin
            soft_clear <= 1'b0;
        end else begin
            soft_clear <= soft_wr;  // one-cycle pulse to core and FIFO
        end
    end

    always_ff @(posedge CLK40) begin
        if (RST_SYNC || soft_wr) begin
            cfg_byte <= '0;
        end else if (bus_wr && bus_add == reg_config) begin
            cfg_byte <= bus_data_in;
        end
    end

    always_ff @(posedge CLK40) begin
        if (RST_SYNC || soft_wr) begin
            event_snap <= '0;
        end else if (bus_rd && bus_add == reg_event_lo) begin
            event_snap <= event_cnt;
        end
    end

    // read data holds until the next read
    always_ff @(posedge CLK40) begin
        if (bus_rd) begin
            case (bus_add)
                reg_soft_rst: bus_data_out <= 8'h00;
                reg_config:   bus_data_out <= cfg_byte;
                reg_lost_cnt: bus_data_out <= lost_cnt;
                reg_event_lo: bus_data_out <= event_cnt[7:0];
                reg_event_hi: bus_data_out <= event_snap[15:8];
                default:      bus_data_out <= 8'h00;
            endcase
        end
    end

    assign cfg = tdc_cfg_t'(cfg_byte[3:0]);  // upper bits are storage only

endmodule

`default_nettype wire

// File: hdl/tdc_sampler.sv
// input stage of the TDC channel
// registers the oversampled word and derives ones count and edge flags
`timescale 1ns/10ps
`default_nettype none

module tdc_sampler (
    input  wire logic        CLK40,
    input  wire logic        RST_SYNC,
    input  wire logic [15:0] tdc_samples,   // bit 0 is newest sample
    output logic      [15:0] sample_word,
    output logic      [4:0]  ones_cnt,
    output logic             one_detected,
    output logic             zero_detected,
    output logic             small_tot,
    output logic             tdc_out
);

    always_ff @(posedge CLK40) begin
        if (RST_SYNC) begin
            sample_word <= '0;
        end else begin
            sample_word <= tdc_samples;
        end
    end

    // population count of the registered word
    always_comb begin
        ones_cnt = '0;
        for (int i = 0; i < 16; i++) begin
            ones_cnt = ones_cnt + 5'(sample_word[i]);
        end
    end

    assign one_detected  = |sample_word;            // any high sample
    assign zero_detected = ~&sample_word;           // any low sample

    // pulse already over inside this word
    assign small_tot = one_detected && !sample_word[0];

    assign tdc_out = one_detected;  // discriminator copy, one register after input

endmodule

`default_nettype wire

// File: hdl/tdc_top.sv
// top level of the TDC channel
// sampler, measurement core, register bank and event FIFO
`timescale 1ns/10ps
`default_nettype none

module tdc_top #(
    parameter logic [3:0] data_identifier = 4'd4,
    parameter int         fifo_depth      = 8
) (
    input  wire logic        CLK40,
    input  wire logic        RST_SYNC,
    input  wire logic [15:0] tdc_samples,
    output logic             tdc_out,
    input  wire logic        arm_tdc,
    input  wire logic        ext_en,
    input  wire logic [15:0] timestamp,
    input  wire logic        fifo_read,
    output logic             fifo_empty,
    output tdc_pkg::tdc_word_t fifo_data,
    input  wire logic [15:0] bus_add,
    input  wire logic [7:0]  bus_data_in,
    input  wire logic        bus_wr,
    input  wire logic        bus_rd,
    output logic      [7:0]  bus_data_out
);
    import tdc_pkg::*;

    logic [4:0]  ones_cnt;
    logic        one_detected;
    logic        zero_detected;
    logic        small_tot;
    tdc_cfg_t    cfg;
    logic        soft_clear;
    tdc_word_t   event_word;
    logic        event_valid;
    logic        fifo_full;
    logic [15:0] event_cnt;
    logic [7:0]  lost_cnt;

    tdc_sampler i_sampler (
        .CLK40         (CLK40),
        .RST_SYNC      (RST_SYNC),
        .tdc_samples   (tdc_samples),
        .sample_word   (),             // raw word only needed inside sampler
        .ones_cnt      (ones_cnt),
        .one_detected  (one_detected),
        .zero_detected (zero_detected),
        .small_tot     (small_tot),
        .tdc_out       (tdc_out)
    );

    tdc_measure #(
        .data_identifier (data_identifier)
    ) i_measure (
        .CLK40         (CLK40),
        .RST_SYNC      (RST_SYNC),
        .soft_clear    (soft_clear),
        .cfg           (cfg),
        .ext_en        (ext_en),
        .arm_tdc       (arm_tdc),
        .timestamp     (timestamp),
        .ones_cnt      (ones_cnt),
        .one_detected  (one_detected),
        .zero_detected (zero_detected),
        .small_tot     (small_tot),
        .fifo_full     (fifo_full),
        .event_word    (event_word),
        .event_valid   (event_valid),
        .event_cnt     (event_cnt),
        .lost_cnt      (lost_cnt)
    );

    tdc_regs i_regs (
        .CLK40        (CLK40),
        .RST_SYNC     (RST_SYNC),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .cfg          (cfg),
        .soft_clear   (soft_clear),
        .event_cnt    (event_cnt),
        .lost_cnt     (lost_cnt)
    );

    tdc_fifo #(
        .depth     (fifo_depth),
        .payload_t (tdc_word_t)
    ) i_fifo (
        .CLK40    (CLK40),
        .RST_SYNC (RST_SYNC),
        .clear    (soft_clear),
        .write    (event_valid),
        .data_in  (event_word),
        .read     (fifo_read),
        .data_out (fifo_data),
        .full     (fifo_full),
        .empty    (fifo_empty)
    );

endmodule

`default_nettype wire

// File: project.f
hdl/tdc_pkg.sv
hdl/tdc_sampler.sv
hdl/tdc_measure.sv
hdl/tdc_regs.sv
hdl/tdc_fifo.sv
hdl/tdc_top.sv
tests/tdc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the TDC channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tdc_tb -f project.f -o sim_tdc || exit 1

sim_out=$(./obj_dir/sim_tdc 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -q "^Finished with no errors$" && exit 0 || exit 1

// File: tests/tdc_tb.sv
// directed testbench for the TDC channel top level
// clock, reset, bus and pulse tasks, typed compare tasks, six tests
`timescale 1ns/10ps
`default_nettype none

module tdc_tb;
    import tdc_pkg::*;

    localparam logic [3:0] data_id     = 4'd4;
    localparam int         fifo_depth  = 8;
    localparam int         pop_timeout = 40;  // cycles

    logic        CLK40;
    logic        RST_SYNC;
    logic [15:0] tdc_samples;
    logic        tdc_out;
    logic        arm_tdc;
    logic        ext_en;
    logic [15:0] timestamp;
    logic        fifo_read;
    logic        fifo_empty;
    tdc_word_t   fifo_data;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_wr;
    logic        bus_rd;
    logic [7:0]  bus_data_out;

    logic [15:0] exp_events;  // model of the event counter

    tdc_top #(
        .data_identifier (data_id),
        .fifo_depth      (fifo_depth)
    ) i_dut (
        .CLK40        (CLK40),
        .RST_SYNC     (RST_SYNC),
        .tdc_samples  (tdc_samples),
        .tdc_out      (tdc_out),
        .arm_tdc      (arm_tdc),
        .ext_en       (ext_en),
        .timestamp    (timestamp),
        .fifo_read    (fifo_read),
        .fifo_empty   (fifo_empty),
        .fifo_data    (fifo_data),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out)
    );

    always #10 CLK40 = ~CLK40;  // 20 ns period

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_word(input string test, input tdc_word_t exp_w, input tdc_word_t act_w);
        if (act_w.ident !== exp_w.ident) begin
            $display("ERR %s ident expected %0d actual %0d", test, exp_w.ident, act_w.ident);
            stop_run();
        end
        if (act_w.stamp !== exp_w.stamp) begin
            $display("ERR %s stamp expected %0d actual %0d", test, exp_w.stamp, act_w.stamp);
            stop_run();
        end
        if (act_w.tot !== exp_w.tot) begin
            $display("ERR %s tot expected %0d actual %0d", test, exp_w.tot, act_w.tot);
            stop_run();
        end
    endtask

    task automatic check_byte(input string test, input logic [7:0] exp_b, input logic [7:0] act_b);
        if (act_b !== exp_b) begin
            $display("ERR %s expected 0x%02h actual 0x%02h", test, exp_b, act_b);
            stop_run();
        end
    endtask

    task automatic check_flag(input string test, input logic exp_f, input logic act_f);
        if (act_f !== exp_f) begin
            $display("ERR %s expected %0b actual %0b", test, exp_f, act_f);
            stop_run();
        end
    endtask

    task automatic check_state(input string test, input tdc_state_t exp_s,
                               input tdc_state_t act_s);
        if (act_s !== exp_s) begin
            $display("ERR %s expected %s actual %s", test, exp_s.name(), act_s.name());
            stop_run();
        end
    endtask

    function automatic tdc_word_t make_word(input logic [15:0] stamp, input logic [11:0] tot);
        tdc_word_t w;
        w.ident = data_id;
        w.stamp = stamp;
        w.tot   = tot;
        return w;
    endfunction

    // n newest samples high as a rising edge inside the word
    function automatic logic [15:0] low_ones(input int n);
        return 16'((32'd1 << n) - 32'd1);
    endfunction

    // all tasks below start and end just after a falling edge
    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(negedge CLK40);
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        bus_add = addr;
        bus_rd  = 1'b1;
        @(negedge CLK40);
        bus_rd = 1'b0;
        data   = bus_data_out;  // registered on the edge just passed
    endtask

    task automatic arm();
        arm_tdc = 1'b1;
        @(negedge CLK40);
        arm_tdc = 1'b0;
    endtask

    task automatic send_words(input logic [15:0] words[$]);
        logic [15:0] ts0;
        ts0 = timestamp;
        foreach (words[i]) begin
            tdc_samples = words[i];
            if (i >= 2) begin
                timestamp = ts0 + 16'(i);  // later words move the timestamp on
            end
            @(negedge CLK40);
            check_flag("pulse tdc_out", |words[i], tdc_out);
        end
        tdc_samples = '0;
        if (words.size() >= 2) begin
            timestamp = ts0 + 16'(words.size());
        end
        @(negedge CLK40);
        check_flag("idle tdc_out", 1'b0, tdc_out);
        repeat (2) @(negedge CLK40);  // let the last event settle
    endtask

    task automatic send_one(input logic [15:0] word);
        logic [15:0] q[$];
        q.push_back(word);
        send_words(q);
    endtask

    // pulse inside one word with newest sample low
    task automatic random_short(output logic [15:0] word, output int n);
        int s;
        n    = int'($urandom % 15) + 1;
        s    = int'($urandom % (16 - n)) + 1;
        word = low_ones(n) << s;
    endtask

    task automatic pop_word(input string test, output tdc_word_t w);
        int waited;
        waited = 0;
        while (fifo_empty) begin
            if (waited >= pop_timeout) begin
                $display("timeout in %s, no event word reached the FIFO", test);
                stop_run();
            end
            @(negedge CLK40);
            waited++;
        end
        w         = fifo_data;  // head word
        fifo_read = 1'b1;
        @(negedge CLK40);
        fifo_read = 1'b0;
    endtask

    task automatic expect_no_word(input string test);
        repeat (4) begin
            check_flag(test, 1'b1, fifo_empty);
            @(negedge CLK40);
        end
    endtask

    task automatic check_event_count(input string test);
        logic [7:0] lo;
        logic [7:0] hi;
        bus_read(reg_event_lo, lo);  // snapshots the high byte
        bus_read(reg_event_hi, hi);
        check_byte({test, " event lo"}, exp_events[7:0], lo);
        check_byte({test, " event hi"}, exp_events[15:8], hi);
    endtask

    task automatic reset_and_registers();
        logic [7:0] b;
        check_flag("reset fifo_empty", 1'b1, fifo_empty);
        check_flag("reset tdc_out", 1'b0, tdc_out);
        check_state("reset state", st_idle, i_dut.i_measure.state);
        for (int a = 0; a < 5; a++) begin
            bus_read(16'(a), b);
            check_byte($sformatf("reset reg %0d", a), 8'h00, b);
        end
        bus_write(reg_config, 8'ha5);
        bus_read(reg_config, b);
        check_byte("config readback", 8'ha5, b);
        bus_write(reg_soft_rst, 8'h01);
        bus_read(reg_config, b);
        check_byte("soft reset config", 8'h00, b);
    endtask

    task automatic short_pulse();
        logic [15:0] word;
        tdc_word_t   w;
        int          n;
        bus_write(reg_config, 8'h01);  // en
        check_event_count("short before");
        random_short(word, n);
        send_one(word);
        pop_word("short", w);
        check_word("short", make_word(exp_events, 12'(n)), w);
        exp_events = exp_events + 16'd1;
        check_event_count("short after");
    endtask

    task automatic long_pulse();
        logic [15:0] q[$];
        logic [15:0] ts;
        tdc_word_t   w;
        int          n;
        int          mid;
        int          m;
        int          sum;
        for (int pass = 0; pass < 2; pass++) begin
            n   = int'($urandom % 16) + 1;  // samples high in start word
            mid = int'($urandom % 5);       // full words in between
            m   = int'($urandom % 16) + 1;  // samples low in end word
            ts  = 16'($urandom);
            sum = n + 16 * mid + (16 - m);
            q.delete();
            q.push_back(low_ones(n));
            for (int i = 0; i < mid; i++) begin
                q.push_back(16'hffff);
            end
            q.push_back(~low_ones(m));
            bus_write(reg_config, (pass == 0) ? 8'h01 : 8'h05);
            timestamp = ts;  // start word timestamp
            send_words(q);
            pop_word($sformatf("long pass %0d", pass), w);
            check_word($sformatf("long pass %0d", pass),
                       make_word((pass == 0) ? exp_events : ts, 12'(sum)), w);
            exp_events = exp_events + 16'd1;
        end
    endtask

    task automatic overflow_pulse();
        logic [15:0] q[$];
        logic [11:0] exp_tot;
        tdc_word_t   w;
        int          sum;
        bus_write(reg_config, 8'h01);
        for (int i = 0; i < 257; i++) begin
            q.push_back(16'hffff);
        end
        q.push_back(16'h0000);
        sum     = 16 * 257;
        exp_tot = (sum > int'(tot_max)) ? 12'd0 : 12'(sum);
        send_words(q);
        pop_word("overflow", w);
        check_word("overflow", make_word(exp_events, exp_tot), w);
        exp_events = exp_events + 16'd1;
    endtask

    task automatic arm_and_enable();
        logic [15:0] word;
        tdc_word_t   w;
        int          n;
        bus_write(reg_config, 8'h03);  // en and en_arm
        random_short(word, n);
        send_one(word);
        expect_no_word("unarmed fifo_empty");
        arm();
        check_state("arm strobe", st_armed, i_dut.i_measure.state);
        random_short(word, n);
        send_one(word);
        pop_word("armed", w);
        check_word("armed", make_word(exp_events, 12'(n)), w);
        exp_events = exp_events + 16'd1;
        check_state("armed done", st_idle, i_dut.i_measure.state);
        bus_write(reg_config, 8'h08);  // en_ext only
        ext_en = 1'b0;
        random_short(word, n);
        send_one(word);
        expect_no_word("ext_en low fifo_empty");
        ext_en = 1'b1;
        random_short(word, n);
        send_one(word);
        pop_word("ext_en high", w);
        check_word("ext_en high", make_word(exp_events, 12'(n)), w);
        exp_events = exp_events + 16'd1;
        ext_en = 1'b0;
    endtask

    task automatic fifo_full_drop();
        logic [15:0] q[$];
        logic [15:0] base;
        logic [7:0]  b;
        tdc_word_t   w;
        bus_write(reg_config, 8'h01);
        base = exp_events;
        for (int i = 0; i < 9; i++) begin
            q.push_back(low_ones(3) << 4);  // tot 3
            q.push_back(16'h0000);
        end
        send_words(q);
        exp_events = exp_events + 16'd9;  // dropped word still counted
        check_flag("full fifo_empty", 1'b0, fifo_empty);
        bus_read(reg_lost_cnt, b);
        check_byte("full lost count", 8'(9 - fifo_depth), b);
        check_event_count("full");
        for (int i = 0; i < fifo_depth; i++) begin
            pop_word($sformatf("full pop %0d", i), w);
            check_word($sformatf("full pop %0d", i), make_word(base + 16'(i), 12'd3), w);
        end
        check_flag("drained fifo_empty", 1'b1, fifo_empty);
    endtask

    initial begin
        void'($urandom(19851));
        CLK40       = 1'b0;
        RST_SYNC    = 1'b1;
        tdc_samples = '0;
        arm_tdc     = 1'b0;
        ext_en      = 1'b0;
        timestamp   = '0;
        fifo_read   = 1'b0;
        bus_add     = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        exp_events  = '0;
        repeat (4) @(posedge CLK40);
        @(negedge CLK40);
        RST_SYNC = 1'b0;
        @(negedge CLK40);
        reset_and_registers();
        short_pulse();
        long_pulse();
        overflow_pulse();
        arm_and_enable();
        fifo_full_drop();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
